// File: cav_pkg.sv
`default_nettype none

package cav_pkg;

	// sample path widths
	localparam int sample_w = 18;
	localparam int gain_w = 16;
	localparam int detune_w = 18;

	// three passband modes, combiner sum grows by mode_ln bits
	localparam int mode_count = 3;
	localparam int mode_ln = 2;

	// host register port
	localparam int addr_w = 4;
	localparam int cfg_w = 32;
	localparam logic [addr_w-1:0] prompt_addr = 4'd15;

	// four-phase slave states
	localparam logic st_idle = 1'b0;
	localparam logic st_ack = 1'b1;

	// detune product is scaled down by 2^17
	localparam int rot_shift = 17;

	// saturation limits of an output sample
	localparam int sat_in_w = 24;
	localparam logic signed [sample_w-1:0] sample_max = {1'b0, {(sample_w-1){1'b1}}};
	localparam logic signed [sample_w-1:0] sample_min = {1'b1, {(sample_w-1){1'b0}}};

	// one config word, read as mode tuning or as coupling gains
	typedef union packed {
		struct packed {
			logic signed [detune_w-1:0] detune;
			// decay rate as a right shift, 1 to 12
			logic [3:0] decay_shift;
			logic [cfg_w-detune_w-5:0] spare;
		} tune;
		struct packed {
			logic [gain_w-1:0] drive_gain;
			logic [gain_w-1:0] probe_gain;
		} couple;
	} cfg_word_t;

	// clamp a wide signed value into one sample
	function automatic logic signed [sample_w-1:0] sat_sample(
		input logic signed [sat_in_w-1:0] x);
		if (x > sample_max)
			return sample_max;
		else if (x < sample_min)
			return sample_min;
		else
			return x[sample_w-1:0];
	endfunction

endpackage

`default_nettype wire

// File: cfg_port.sv
`timescale 1ns/1ns
`default_nettype none

module cfg_port (
	input wire clk,
	input wire reset,
	// host side, four-phase req/ack
	input wire req,
	input wire we,
	input wire [cav_pkg::addr_w-1:0] addr,
	input wire cav_pkg::cfg_word_t wdata,
	output wire ack,
	output cav_pkg::cfg_word_t rdata,
	// coefficient registers
	output cav_pkg::cfg_word_t tuning [cav_pkg::mode_count],
	output cav_pkg::cfg_word_t coupling [cav_pkg::mode_count],
	output logic [cav_pkg::gain_w-1:0] prompt_gain
);
	import cav_pkg::*;

	logic state;
	cfg_word_t read_word;
	logic access;

	// ack is simply the state bit
	assign ack = (state == st_ack);

	// one access per handshake, taken on the idle to ack transition
	assign access = (state == st_idle) && req;

	// read mux
	// unmapped addresses fall through to zero
	always_comb begin
		read_word = '0;
		for (int n = 0; n < mode_count; n++) begin
			if (addr == addr_w'(2*n))
				read_word = tuning[n];
			if (addr == addr_w'(2*n+1))
				read_word = coupling[n];
		end
		if (addr == prompt_addr)
			read_word = {{(cfg_w-gain_w){1'b0}}, prompt_gain};
	end

	// slave FSM and register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			prompt_gain <= '0;
			for (int n = 0; n < mode_count; n++) begin
				tuning[n] <= '0;
				coupling[n] <= '0;
			end
		end else begin
			case (state)
				st_idle: begin
					if (req)
						state <= st_ack;
					if (access && we) begin
						for (int n = 0; n < mode_count; n++) begin
							if (addr == addr_w'(2*n))
								tuning[n] <= wdata;
							if (addr == addr_w'(2*n+1))
								coupling[n] <= wdata;
						end
						// prompt gain sits in the low half
						if (addr == prompt_addr)
							prompt_gain <= wdata[gain_w-1:0];
					end
				end
				st_ack: begin
					// hold ack until the host drops req
					if (!req)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// read data, valid while ack is high
	always_ff @(posedge clk) begin
		if (access && !we)
			rdata <= read_word;
	end

endmodule

`default_nettype wire

// File: drive_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module drive_frontend (
	input wire clk,
	input wire reset,
	// interleaved drive, I when iq is high
	input wire iq,
	input wire signed [cav_pkg::sample_w-1:0] drive,
	input wire [cav_pkg::gain_w-1:0] prompt_gain,
	// registered copies for the modes and the combiner
	output logic iq_r,
	output logic signed [cav_pkg::sample_w-1:0] drive_r,
	output logic signed [cav_pkg::sample_w-1:0] fwd
);
	import cav_pkg::*;

	// drive times unsigned gain, gain zero-extended to stay positive
	logic signed [sample_w+gain_w:0] fwd_prod;

	assign fwd_prod = drive * $signed({1'b0, prompt_gain});

	// one clock of pipeline
	// phase flag travels alongside its sample
	always_ff @(posedge clk) begin
		if (reset) begin
			iq_r <= 1'b0;
			drive_r <= '0;
			fwd <= '0;
		end else begin
			iq_r <= iq;
			drive_r <= drive;
			// prompt forward wave, scaled down by 2^16
			// gain below unity so the result always fits one sample
			fwd <= fwd_prod[sample_w+gain_w-1:gain_w];
		end
	end

endmodule

`default_nettype wire

// File: cav_mode.sv
`timescale 1ns/1ns
`default_nettype none

module cav_mode (
	input wire clk,
	input wire reset,
	// interleaved drive from the front end
	input wire iq,
	input wire signed [cav_pkg::sample_w-1:0] drive,
	// per-mode coefficients
	input wire cav_pkg::cfg_word_t tuning,
	input wire cav_pkg::cfg_word_t coupling,
	// probe signal, interleaved like the drive
	output logic signed [cav_pkg::sample_w-1:0] probe
);
	import cav_pkg::*;

	// decoded coefficients
	wire signed [detune_w-1:0] detune;
	wire [3:0] decay_shift;
	wire [gain_w-1:0] drive_gain;
	wire [gain_w-1:0] probe_gain;

	// complex mode state
	logic signed [sample_w-1:0] vi;
	logic signed [sample_w-1:0] vq;
	// old vi, for the Q half of the rotation
	logic signed [sample_w-1:0] vi_old;
	// iq of the component just updated
	logic iq_d;

	// state update datapath
	logic signed [sample_w+gain_w:0] drive_prod;
	logic signed [sample_w-1:0] drive_term;
	logic signed [sample_w:0] err;
	logic signed [sample_w:0] err_dec;
	logic signed [detune_w+sample_w-1:0] rot_prod;
	logic signed [detune_w+sample_w-rot_shift-1:0] rot_term;
	logic signed [sample_w+2:0] next_v;

	// probe scaling
	logic signed [sample_w+gain_w:0] probe_prod;

	assign detune = tuning.tune.detune;
	assign decay_shift = tuning.tune.decay_shift;
	assign drive_gain = coupling.couple.drive_gain;
	assign probe_gain = coupling.couple.probe_gain;

	// coupled drive, scaled down by 2^16
	assign drive_prod = drive * $signed({1'b0, drive_gain});
	assign drive_term = drive_prod[sample_w+gain_w-1:gain_w];

	// error between coupled drive and the component being updated
	assign err = drive_term - (iq ? vi : vq);

	// first-order decay toward the driven value
	assign err_dec = err >>> decay_shift;

	// detuning rotates the state
	// the I step uses vq, the Q step uses vi from before the I step
	assign rot_prod = detune * (iq ? vq : vi_old);
	assign rot_term = rot_prod[detune_w+sample_w-1:rot_shift];

	// opposite signs on the cross term make it a rotation
	assign next_v = iq ? (vi + err_dec - rot_term) : (vq + err_dec + rot_term);

	// stage 1 updates one component per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			vi <= '0;
			vq <= '0;
			vi_old <= '0;
			iq_d <= 1'b0;
		end else begin
			iq_d <= iq;
			if (iq) begin
				vi <= sat_sample(next_v);
				vi_old <= vi;
			end else begin
				vq <= sat_sample(next_v);
			end
		end
	end

	// probe coupling of whichever component was just written
	assign probe_prod = (iq_d ? vi : vq) * $signed({1'b0, probe_gain});

	// stage 2 scales it by the probe gain
	always_ff @(posedge clk) begin
		if (reset)
			probe <= '0;
		else
			probe <= probe_prod[sample_w+gain_w-1:gain_w];
	end

endmodule

`default_nettype wire

// File: probe_combiner.sv
`timescale 1ns/1ns
`default_nettype none

module probe_combiner (
	input wire clk,
	input wire reset,
	// phase flag and prompt wave from the front end
	input wire iq,
	input wire signed [cav_pkg::sample_w-1:0] fwd,
	// one probe per mode
	input wire signed [cav_pkg::sample_w-1:0] probes [cav_pkg::mode_count],
	// interleaved outputs
	output logic out_iq,
	output logic signed [cav_pkg::sample_w-1:0] field,
	output logic signed [cav_pkg::sample_w-1:0] forward,
	output logic signed [cav_pkg::sample_w-1:0] reflect
);
	import cav_pkg::*;

	// two-clock match for the mode pipeline
	logic iq_d1;
	logic iq_d2;
	logic signed [sample_w-1:0] fwd_d1;
	logic signed [sample_w-1:0] fwd_d2;

	// mode sum with mode_ln bits of headroom
	logic signed [sample_w+mode_ln-1:0] probe_sum;
	// one more bit for the difference
	logic signed [sample_w+mode_ln:0] refl_sum;

	// single-cycle adder tree over all modes
	always_comb begin
		probe_sum = '0;
		for (int n = 0; n < mode_count; n++)
			probe_sum = probe_sum + probes[n];
	end

	// reflected wave is the prompt wave less the cavity emission
	assign refl_sum = fwd_d2 - probe_sum;

	// phase flag delay
	always_ff @(posedge clk) begin
		if (reset) begin
			iq_d1 <= 1'b0;
			iq_d2 <= 1'b0;
		end else begin
			iq_d1 <= iq;
			iq_d2 <= iq_d1;
		end
	end

	// prompt wave delay
	always_ff @(posedge clk) begin
		fwd_d1 <= fwd;
		fwd_d2 <= fwd_d1;
	end

	// output register, saturated to one sample
	always_ff @(posedge clk) begin
		if (reset) begin
			out_iq <= 1'b0;
			field <= '0;
			forward <= '0;
			reflect <= '0;
		end else begin
			out_iq <= iq_d2;
			field <= sat_sample(probe_sum);
			forward <= fwd_d2;
			reflect <= sat_sample(refl_sum);
		end
	end

endmodule

`default_nettype wire

// File: cav_elec.sv
`timescale 1ns/1ns
`default_nettype none

module cav_elec (
	input wire clk,
	input wire reset,
	// drive stream, I when iq is high
	input wire iq,
	input wire signed [cav_pkg::sample_w-1:0] drive,
	// host register port
	input wire req,
	input wire we,
	input wire [cav_pkg::addr_w-1:0] addr,
	input wire cav_pkg::cfg_word_t wdata,
	output wire ack,
	output wire cav_pkg::cfg_word_t rdata,
	// baseband outputs, still interleaved
	output wire signed [cav_pkg::sample_w-1:0] field,
	output wire signed [cav_pkg::sample_w-1:0] forward,
	output wire signed [cav_pkg::sample_w-1:0] reflect,
	output wire out_iq
);
	import cav_pkg::*;

	// coefficients from the register port
	wire cfg_word_t tuning [mode_count];
	wire cfg_word_t coupling [mode_count];
	wire [gain_w-1:0] prompt_gain;

	// front end to modes and combiner
	wire iq_r;
	wire signed [sample_w-1:0] drive_r;
	wire signed [sample_w-1:0] fwd;

	// mode probes to combiner
	wire signed [sample_w-1:0] probes [mode_count];

	cfg_port cfg0 (
		.clk(clk),
		.reset(reset),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.tuning(tuning),
		.coupling(coupling),
		.prompt_gain(prompt_gain)
	);

	drive_frontend front0 (
		.clk(clk),
		.reset(reset),
		.iq(iq),
		.drive(drive),
		.prompt_gain(prompt_gain),
		.iq_r(iq_r),
		.drive_r(drive_r),
		.fwd(fwd)
	);

	// every mode sees the same drive
	genvar n;
	generate
		for (n = 0; n < mode_count; n++) begin : g_mode
			cav_mode mode (
				.clk(clk),
				.reset(reset),
				.iq(iq_r),
				.drive(drive_r),
				.tuning(tuning[n]),
				.coupling(coupling[n]),
				.probe(probes[n])
			);
		end
	endgenerate

	probe_combiner comb0 (
		.clk(clk),
		.reset(reset),
		.iq(iq_r),
		.fwd(fwd),
		.probes(probes),
		.out_iq(out_iq),
		.field(field),
		.forward(forward),
		.reflect(reflect)
	);

endmodule

`default_nettype wire

// File: cav_elec_props.sv
`timescale 1ns/1ns
`default_nettype none

module cav_elec_props (
	input wire clk,
	input wire reset,
	input wire req,
	input wire ack,
	input wire out_iq
);
	// failure count
	int fails = 0;
	// clocks since reset, out_iq needs a few to fill the pipeline
	logic [2:0] run_cnt;

	always_ff @(posedge clk) begin
		if (reset)
			run_cnt <= '0;
		else if (run_cnt != 3'd6)
			run_cnt <= run_cnt + 3'd1;
	end

	// ack only answers an open request
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req))
		else begin
			fails++;
			$error("ack rose without a request");
		end

	// slave lets go one clock after the host
	ack_follows_req: assert property (@(posedge clk) disable iff (reset)
		$fell(req) |=> !ack)
		else begin
			fails++;
			$error("ack still high one clock after req fell");
		end

	// interleaved stream never stalls
	out_iq_toggles: assert property (@(posedge clk) disable iff (reset)
		(run_cnt == 3'd6) |-> (out_iq != $past(out_iq)))
		else begin
			fails++;
			$error("out_iq did not toggle");
		end

endmodule

bind cav_elec cav_elec_props props0 (
	.clk(clk),
	.reset(reset),
	.req(req),
	.ack(ack),
	.out_iq(out_iq)
);

`default_nettype wire

// File: cav_elec_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cav_elec_tb;
	import cav_pkg::*;

	localparam int row_count = 4;
	localparam int clk_half = 4;
	localparam int reset_cycles = 10;

	// one configuration set and the drive it runs with
	typedef struct {
		cfg_word_t tun [mode_count];
		cfg_word_t cpl [mode_count];
		int pg;
		bit rnd;
		int di;
		int dq;
		int pairs;
		bit settle;
	} row_t;

	// expected outputs of one drive sample
	typedef struct packed {
		logic iq;
		logic signed [sample_w-1:0] field;
		logic signed [sample_w-1:0] fwd;
		logic signed [sample_w-1:0] refl;
		logic settle;
		logic signed [sample_w-1:0] settle_val;
	} exp_t;

	logic clk;
	logic reset;
	logic iq;
	logic signed [sample_w-1:0] drive;
	logic req;
	logic we;
	logic [addr_w-1:0] addr;
	cfg_word_t wdata;
	wire ack;
	wire cfg_word_t rdata;
	wire signed [sample_w-1:0] field;
	wire signed [sample_w-1:0] forward;
	wire signed [sample_w-1:0] reflect;
	wire out_iq;

	row_t rows [row_count];
	bit table_ready;
	exp_t expq [$];

	// reference model state and coefficients
	int vi_m [mode_count];
	int vq_m [mode_count];
	int vio_m [mode_count];
	int det_m [mode_count];
	int sh_m [mode_count];
	int dg_m [mode_count];
	int pgn_m [mode_count];
	int pg_m;

	// stream control
	bit model_on;
	bit phase;
	bit cur_rnd;
	int cur_di;
	int cur_dq;
	bit settle_next;
	int settle_val;
	logic [31:0] rng;

	int checks;
	int mismatches;
	int other_errors;

	cav_elec dut0 (
		.clk(clk),
		.reset(reset),
		.iq(iq),
		.drive(drive),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.field(field),
		.forward(forward),
		.reflect(reflect),
		.out_iq(out_iq)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// clamp to one 18-bit sample
	function automatic longint clamp18(input longint x);
		if (x > 131071)
			return 131071;
		if (x < -131072)
			return -131072;
		return x;
	endfunction

	function automatic cfg_word_t tune_word(input int det, input int sh);
		cfg_word_t w;
		w = '0;
		w.tune.detune = det[detune_w-1:0];
		w.tune.decay_shift = sh[3:0];
		return w;
	endfunction

	function automatic cfg_word_t couple_word(input int dg, input int pgn);
		cfg_word_t w;
		w.couple.drive_gain = dg[gain_w-1:0];
		w.couple.probe_gain = pgn[gain_w-1:0];
		return w;
	endfunction

	task automatic set_mode(input int r, input int n, input int det, input int sh,
			input int dg, input int pgn);
		rows[r].tun[n] = tune_word(det, sh);
		rows[r].cpl[n] = couple_word(dg, pgn);
	endtask

	task automatic set_row(input int r, input int pg, input bit rnd, input int di,
			input int dq, input int pairs, input bit settle);
		rows[r].pg = pg;
		rows[r].rnd = rnd;
		rows[r].di = di;
		rows[r].dq = dq;
		rows[r].pairs = pairs;
		rows[r].settle = settle;
	endtask

	task automatic fill_table();
		// all coefficients zero, random drive must not leak through
		for (int n = 0; n < mode_count; n++)
			set_mode(0, n, 0, 0, 0, 0);
		set_row(0, 0, 1'b1, 0, 0, 60, 1'b0);
		// step into mode 0 alone
		set_mode(1, 0, 0, 3, 40000, 50000);
		set_mode(1, 1, 0, 2, 0, 0);
		set_mode(1, 2, 0, 2, 0, 0);
		set_row(1, 30000, 1'b0, 60000, -20000, 120, 1'b1);
		// three detuned modes, random drive
		set_mode(2, 0, 20000, 2, 30000, 45000);
		set_mode(2, 1, -35000, 4, 50000, 20000);
		set_mode(2, 2, 8000, 1, 20000, 60000);
		set_row(2, 45000, 1'b1, 0, 0, 200, 1'b0);
		// full scale, sum runs past 18 bits
		for (int n = 0; n < mode_count; n++)
			set_mode(3, n, 0, 1, 65535, 65535);
		set_row(3, 65535, 1'b0, 131071, -131072, 60, 1'b0);
	endtask

	// one sample through the integer model of the cavity
	task automatic model_step(input bit b, input int d, output exp_t e);
		longint dt;
		longint err;
		longint rot;
		longint nv;
		longint pr;
		longint sum;
		longint f;
		e = '0;
		sum = 0;
		f = (longint'(d) * pg_m) >>> 16;
		for (int n = 0; n < mode_count; n++) begin
			dt = (longint'(d) * dg_m[n]) >>> 16;
			if (b) begin
				err = dt - vi_m[n];
				rot = (longint'(det_m[n]) * vq_m[n]) >>> 17;
				nv = vi_m[n] + (err >>> sh_m[n]) - rot;
				vio_m[n] = vi_m[n];
				vi_m[n] = int'(clamp18(nv));
				pr = (longint'(vi_m[n]) * pgn_m[n]) >>> 16;
			end else begin
				// Q step rotates with the vi from before the I step
				err = dt - vq_m[n];
				rot = (longint'(det_m[n]) * vio_m[n]) >>> 17;
				nv = vq_m[n] + (err >>> sh_m[n]) + rot;
				vq_m[n] = int'(clamp18(nv));
				pr = (longint'(vq_m[n]) * pgn_m[n]) >>> 16;
			end
			sum = sum + pr;
		end
		e.iq = b;
		e.field = clamp18(sum);
		e.fwd = f;
		e.refl = clamp18(f - sum);
	endtask

	task automatic compare(input string name, input logic signed [sample_w-1:0] exp_v,
			input logic signed [sample_w-1:0] act_v);
		checks++;
		if (act_v !== exp_v) begin
			mismatches++;
			$display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_outputs(input exp_t e);
		compare("out_iq", e.iq, out_iq);
		compare("field", e.field, field);
		compare("forward", e.fwd, forward);
		compare("reflect", e.refl, reflect);
		if (e.settle) begin
			checks++;
			if (field > e.settle_val + 16 || field < e.settle_val - 16) begin
				other_errors++;
				$display("field settled at %0d, too far from the steady state %0d",
					field, e.settle_val);
			end
		end
	endtask

	// one clock: check the sample from 4 clocks back, then drive the next one
	task automatic tick();
		exp_t e;
		int d;
		@(posedge clk);
		#1;
		if (expq.size() == 4 || (!model_on && expq.size() > 0)) begin
			e = expq.pop_front();
			check_outputs(e);
		end
		d = 0;
		if (model_on) begin
			// no host access is open while the stream is checked
			checks++;
			if (ack !== 1'b0) begin
				other_errors++;
				$display("ack is high at %0t ns with no host access open", $time);
			end
			if (cur_rnd) begin
				rng = xorshift32(rng);
				d = $signed(rng[sample_w-1:0]);
			end else begin
				d = phase ? cur_di : cur_dq;
			end
			model_step(phase, d, e);
			e.settle = settle_next && phase;
			e.settle_val = settle_val;
			if (phase)
				settle_next = 1'b0;
			expq.push_back(e);
		end
		iq = phase;
		drive = d;
		phase = !phase;
	endtask

	// four-phase access on the host port
	task automatic host_access(input logic wr, input logic [addr_w-1:0] a,
			input cfg_word_t wd, output cfg_word_t rd);
		int n;
		req = 1'b1;
		we = wr;
		addr = a;
		wdata = wd;
		tick();
		for (n = 0; n < 8 && ack !== 1'b1; n++)
			tick();
		rd = rdata;
		checks++;
		if (ack !== 1'b1) begin
			other_errors++;
			$display("no ack from the register port for address %0d", a);
		end
		req = 1'b0;
		tick();
		for (n = 0; n < 8 && ack !== 1'b0; n++)
			tick();
		checks++;
		if (ack !== 1'b0) begin
			other_errors++;
			$display("ack did not fall after req fell, address %0d", a);
		end
	endtask

	task automatic host_write(input logic [addr_w-1:0] a, input cfg_word_t w);
		cfg_word_t unused;
		host_access(1'b1, a, w, unused);
	endtask

	task automatic read_back(input logic [addr_w-1:0] a, input cfg_word_t expw);
		cfg_word_t got;
		host_access(1'b0, a, '0, got);
		checks++;
		if (got !== expw) begin
			mismatches++;
			$display("MISMATCH at %0t ns: rdata expected %h, got %h", $time, expw, got);
		end
	endtask

	task automatic run_row(input int r);
		cfg_word_t pg_word;
		longint dt0;
		pg_word = '0;
		pg_word[gain_w-1:0] = rows[r].pg[gain_w-1:0];
		// zero tuning pulls each mode state to the zero drive within one pair
		for (int n = 0; n < mode_count; n++)
			host_write(addr_w'(2*n), '0);
		for (int n = 0; n < mode_count; n++) begin
			host_write(addr_w'(2*n), rows[r].tun[n]);
			host_write(addr_w'(2*n+1), rows[r].cpl[n]);
		end
		host_write(prompt_addr, pg_word);
		for (int n = 0; n < mode_count; n++) begin
			read_back(addr_w'(2*n), rows[r].tun[n]);
			read_back(addr_w'(2*n+1), rows[r].cpl[n]);
		end
		read_back(prompt_addr, pg_word);
		// first address past the modes is unmapped
		read_back(addr_w'(2*mode_count), '0);
		// pipeline is all zero here
		for (int n = 0; n < mode_count; n++) begin
			det_m[n] = rows[r].tun[n].tune.detune;
			sh_m[n] = rows[r].tun[n].tune.decay_shift;
			dg_m[n] = rows[r].cpl[n].couple.drive_gain;
			pgn_m[n] = rows[r].cpl[n].couple.probe_gain;
			vi_m[n] = 0;
			vq_m[n] = 0;
			vio_m[n] = 0;
		end
		pg_m = rows[r].pg;
		cur_rnd = rows[r].rnd;
		cur_di = rows[r].di;
		cur_dq = rows[r].dq;
		// steady I field of mode 0 under constant drive
		dt0 = (longint'(rows[r].di) * dg_m[0]) >>> 16;
		settle_val = int'((dt0 * pgn_m[0]) >>> 16);
		model_on = 1'b1;
		for (int p = 0; p < rows[r].pairs; p++) begin
			settle_next = rows[r].settle && (p == rows[r].pairs - 1);
			tick();
			tick();
		end
		model_on = 1'b0;
		// last samples leave the pipeline before the next coefficient writes
		while (expq.size() > 0)
			tick();
	endtask

	initial begin
		fill_table();
		table_ready = 1'b1;
		reset = 1'b1;
		iq = 1'b0;
		drive = '0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		rng = 32'h932604ee;
		phase = 1'b1;
		model_on = 1'b0;
		cur_rnd = 1'b0;
		cur_di = 0;
		cur_dq = 0;
		settle_next = 1'b0;
		settle_val = 0;
		checks = 0;
		mismatches = 0;
		other_errors = 0;
		repeat (reset_cycles) tick();
		reset = 1'b0;
		for (int r = 0; r < row_count; r++)
			run_row(r);
		$display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
			checks, mismatches, other_errors, dut0.props0.fails);
		if (mismatches == 0 && other_errors == 0 && dut0.props0.fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		longint budget;
		wait (table_ready);
		budget = reset_cycles * 2 * clk_half;
		for (int r = 0; r < row_count; r++)
			budget = budget + (rows[r].pairs * 2 + 40) * 2 * clk_half;
		#(budget);
		$display("timeout: run did not finish within %0d ns", budget);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
cav_pkg.sv
cfg_port.sv
drive_frontend.sv
cav_mode.sv
probe_combiner.sv
cav_elec.sv
cav_elec_props.sv
cav_elec_tb.sv
